//--- verilog.f
axil_pkg.sv
reg_stream_pkg.sv
stream_stage.sv
axil_reg_front.sv
ext_reg_bank.sv
ext_regs_top.sv
ext_regs_props.sv
ext_regs_tb.sv

//--- Makefile
TOP = ext_regs_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f verilog.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir

//--- ext_regs_tb.sv
// Register bridge testbench: AXI-lite driver tasks, stimulus table, random phase, timeout
`default_nettype none

module ext_regs_tb
    import axil_pkg::*;
();

    localparam int N_CTRL     = 4;
    localparam int N_STAT     = 2;
    localparam int N_TABLE    = 22;
    localparam int N_RANDOM   = 40;
    localparam int MAX_CYCLES = (N_TABLE + N_RANDOM) * 20;
    localparam logic OP_RD    = 1'b0;
    localparam logic OP_WR    = 1'b1;

    typedef struct packed {
        logic       is_write;
        axil_addr_t addr;
        axil_data_t data;
        axil_resp_t resp;
        logic [3:0] stall;
    } op_t;

    logic                    clk = 1'b0;
    logic                    rst_n;
    axil_req_t               axil_req;
    axil_rsp_t               axil_rsp;
    logic [N_STAT-1:0][31:0] status;
    logic [N_CTRL-1:0][31:0] ctrl;
    logic [31:0]             ctrl_model [N_CTRL];
    logic [31:0]             lcg_state;
    int                      cycles = 0;

    // Kind, byte address, write data, expected response, cycles with r_ready low
    op_t ops [N_TABLE] = '{
        '{OP_RD, 32'h0000_0000, 32'h0000_0000, RESP_OKAY,   4'd0},
        '{OP_RD, 32'h0000_0004, 32'h0000_0000, RESP_OKAY,   4'd0},
        '{OP_RD, 32'h0000_0008, 32'h0000_0000, RESP_OKAY,   4'd0},
        '{OP_RD, 32'h0000_000c, 32'h0000_0000, RESP_OKAY,   4'd0},
        '{OP_WR, 32'h0000_0000, 32'h1111_1111, RESP_OKAY,   4'd0},
        '{OP_WR, 32'h0000_0004, 32'hdead_beef, RESP_OKAY,   4'd0},
        '{OP_WR, 32'h0000_0008, 32'h0000_00a5, RESP_OKAY,   4'd0},
        '{OP_WR, 32'h0000_000c, 32'h8000_0001, RESP_OKAY,   4'd0},
        '{OP_RD, 32'h0000_0000, 32'h0000_0000, RESP_OKAY,   4'd0},
        '{OP_RD, 32'h0000_000c, 32'h0000_0000, RESP_OKAY,   4'd0},
        // Status words are read-only
        '{OP_RD, 32'h0000_0010, 32'h0000_0000, RESP_OKAY,   4'd0},
        '{OP_RD, 32'h0000_0014, 32'h0000_0000, RESP_OKAY,   4'd0},
        '{OP_WR, 32'h0000_0010, 32'hffff_ffff, RESP_SLVERR, 4'd0},
        '{OP_WR, 32'h0000_0014, 32'h0bad_0bad, RESP_SLVERR, 4'd0},
        // Beyond the map, two of them alias control words in their low bits
        '{OP_RD, 32'h0000_0018, 32'h0000_0000, RESP_SLVERR, 4'd0},
        '{OP_WR, 32'h0000_001c, 32'h7777_7777, RESP_SLVERR, 4'd0},
        '{OP_WR, 32'h4000_0000, 32'h5555_5555, RESP_SLVERR, 4'd0},
        '{OP_RD, 32'h4000_0004, 32'h0000_0000, RESP_SLVERR, 4'd0},
        // Stalled read, then a write right after its response
        '{OP_RD, 32'h0000_0008, 32'h0000_0000, RESP_OKAY,   4'd6},
        '{OP_WR, 32'h0000_0008, 32'h1234_5678, RESP_OKAY,   4'd0},
        '{OP_RD, 32'h0000_0008, 32'h0000_0000, RESP_OKAY,   4'd0},
        '{OP_RD, 32'h0000_0014, 32'h0000_0000, RESP_OKAY,   4'd3}
    };

    ext_regs_top #(.N_CTRL(N_CTRL), .N_STAT(N_STAT)) dut (
        .clk(clk),
        .rst_n(rst_n),
        .axil_req(axil_req),
        .axil_rsp(axil_rsp),
        .status(status),
        .ctrl(ctrl)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: no progress within %0d clock cycles", MAX_CYCLES);
            $display("Testbench failed");
            $fatal(1, "Run stopped at the cycle limit");
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail at time %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("Testbench failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Writes only land in control words, reads cover control and status words
    function automatic axil_resp_t map_resp(input logic is_write, input logic [31:0] addr);
        logic [31:0] word;
        word = addr >> 2;
        if (is_write) begin
            return (word < 32'(N_CTRL)) ? RESP_OKAY : RESP_SLVERR;
        end else begin
            return (word < 32'(N_CTRL + N_STAT)) ? RESP_OKAY : RESP_SLVERR;
        end
    endfunction

    function automatic logic [31:0] read_model(input logic [31:0] addr);
        logic [31:0] word;
        logic [31:0] value;
        word  = addr >> 2;
        value = '0;
        for (int i = 0; i < N_CTRL; i++) begin
            if (word == 32'(i)) begin
                value = ctrl_model[i];
            end
        end
        for (int j = 0; j < N_STAT; j++) begin
            if (word == 32'(N_CTRL + j)) begin
                value = status[j];
            end
        end
        return value;
    endfunction

    task automatic check_ctrl_outputs();
        for (int i = 0; i < N_CTRL; i++) begin
            check_value($sformatf("ctrl[%0d]", i), ctrl[i], ctrl_model[i]);
        end
    endtask

    // Called on a falling edge, returns on a falling edge
    task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                              output axil_resp_t resp);
        logic accepted;
        accepted          = 1'b0;
        axil_req.aw_valid = 1'b1;
        axil_req.aw_addr  = addr;
        axil_req.w_valid  = 1'b1;
        axil_req.w_data   = data;
        while (!accepted) begin
            @(posedge clk);
            accepted = axil_rsp.aw_ready && axil_rsp.w_ready;
        end
        @(negedge clk);
        axil_req.aw_valid = 1'b0;
        axil_req.w_valid  = 1'b0;
        while (!axil_rsp.b_valid) begin
            @(negedge clk);
        end
        resp             = axil_rsp.b_resp;
        axil_req.b_ready = 1'b1;
        @(negedge clk);
        axil_req.b_ready = 1'b0;
    endtask

    // Latency counts rising edges from the AR handshake until r_valid shows
    task automatic axil_read(input logic [31:0] addr, input int stall, output logic [31:0] data,
                             output axil_resp_t resp, output int latency);
        logic accepted;
        accepted          = 1'b0;
        latency           = 0;
        axil_req.ar_valid = 1'b1;
        axil_req.ar_addr  = addr;
        axil_req.r_ready  = (stall == 0);
        while (!accepted) begin
            @(posedge clk);
            accepted = axil_rsp.ar_ready;
        end
        @(negedge clk);
        axil_req.ar_valid = 1'b0;
        while (!axil_rsp.r_valid) begin
            @(negedge clk);
            latency++;
        end
        data = axil_rsp.r_data;
        resp = axil_rsp.r_resp;
        for (int k = 0; k < stall; k++) begin
            @(negedge clk);
            check_value("r_valid", 32'(axil_rsp.r_valid), 32'd1);
            check_value("r_data", axil_rsp.r_data, data);
        end
        axil_req.r_ready = 1'b1;
        @(negedge clk);
        axil_req.r_ready = 1'b0;
    endtask

    task automatic run_op(input logic is_write, input logic [31:0] addr, input logic [31:0] data,
                          input axil_resp_t exp_resp, input int stall);
        axil_resp_t  resp;
        logic [31:0] rdata;
        logic [31:0] exp_data;
        int          latency;
        if (is_write) begin
            axil_write(addr, data, resp);
            check_value("b_resp", 32'(resp), 32'(exp_resp));
            for (int i = 0; i < N_CTRL; i++) begin
                if (exp_resp == RESP_OKAY && (addr >> 2) == 32'(i)) begin
                    ctrl_model[i] = data;
                end
            end
            // Control output follows two edges after the handshake
            @(negedge clk);
            check_ctrl_outputs();
        end else begin
            exp_data = (exp_resp == RESP_OKAY) ? read_model(addr) : 32'd0;
            axil_read(addr, stall, rdata, resp, latency);
            check_value("r_resp", 32'(resp), 32'(exp_resp));
            check_value("r_data", rdata, exp_data);
            check_value("r_valid latency", latency, (exp_resp == RESP_OKAY) ? 32'd4 : 32'd0);
        end
    endtask

    initial begin
        logic [31:0] sel;
        logic [31:0] addr;
        axil_req  = '0;
        rst_n     = 1'b0;
        status[0] = 32'h5a5a_0001;
        status[1] = 32'hc3c3_0002;
        lcg_state = 32'h16a4f66c;
        for (int i = 0; i < N_CTRL; i++) begin
            ctrl_model[i] = '0;
        end
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        check_ctrl_outputs();

        for (int k = 0; k < N_TABLE; k++) begin
            run_op(ops[k].is_write, ops[k].addr, ops[k].data, ops[k].resp, int'(ops[k].stall));
        end

        // Fresh status values, then mixed traffic across and just past the map
        status[0] = next_random();
        status[1] = next_random();
        for (int k = 0; k < N_RANDOM; k++) begin
            sel  = next_random();
            addr = {27'd0, sel[30:28], 2'b00};
            if (sel[25:24] == 2'b11) begin
                addr[31:28] = sel[19:16] | 4'h1;
            end
            run_op(sel[31], addr, next_random(), map_resp(sel[31], addr), int'(sel[21:20]));
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- ext_regs_props.sv
// Concurrent assertions on the AXI-lite handshake and stream issue, bound to axil_reg_front
`default_nettype none

module ext_regs_props
    import axil_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input axil_req_t axil_req,
    input axil_rsp_t axil_rsp,
    input logic      wr_valid,
    input logic      rd_addr_valid
);

    // A pending response stays up until the master takes it
    b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.b_valid && !axil_req.b_ready |=> axil_rsp.b_valid)
        else $error("b_valid dropped before b_ready");

    r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.r_valid && !axil_req.r_ready |=> axil_rsp.r_valid)
        else $error("r_valid dropped before r_ready");

    r_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.r_valid && !axil_req.r_ready |=> $stable(axil_rsp.r_data))
        else $error("r_data changed while waiting for r_ready");

    // Write and read items never leave together, which keeps the paths ordered
    stream_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(wr_valid && rd_addr_valid))
        else $error("write item and read item issued in the same cycle");

endmodule

bind axil_reg_front ext_regs_props props (
    .clk(clk),
    .rst_n(rst_n),
    .axil_req(axil_req),
    .axil_rsp(axil_rsp),
    .wr_valid(wr_valid),
    .rd_addr_valid(rd_addr_valid)
);

`default_nettype wire

//--- ext_regs_top.sv
// Register bridge top level: front end, three pipeline stages and register bank
`default_nettype none

module ext_regs_top
    import axil_pkg::*, reg_stream_pkg::*;
#(
    parameter int N_CTRL = 4,
    parameter int N_STAT = 2
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  axil_req_t               axil_req,
    output axil_rsp_t               axil_rsp,
    input  logic [N_STAT-1:0][31:0] status,
    output logic [N_CTRL-1:0][31:0] ctrl
);

    // Front end side of each link
    logic          fe_wr_valid, fe_wr_ready;
    wr_item_t      fe_wr_item;
    logic          fe_rd_addr_valid, fe_rd_addr_ready;
    rd_addr_item_t fe_rd_addr_item;
    logic          fe_rd_data_valid, fe_rd_data_ready;
    rd_data_item_t fe_rd_data_item;

    // Bank side of each link
    logic          bk_wr_valid, bk_wr_ready;
    wr_item_t      bk_wr_item;
    logic          bk_rd_addr_valid, bk_rd_addr_ready;
    rd_addr_item_t bk_rd_addr_item;
    logic          bk_rd_data_valid, bk_rd_data_ready;
    rd_data_item_t bk_rd_data_item;

    axil_reg_front #(.N_CTRL(N_CTRL), .N_STAT(N_STAT)) front (
        .clk, .rst_n, .axil_req, .axil_rsp,
        .wr_valid(fe_wr_valid), .wr_ready(fe_wr_ready), .wr_item(fe_wr_item),
        .rd_addr_valid(fe_rd_addr_valid), .rd_addr_ready(fe_rd_addr_ready),
        .rd_addr_item(fe_rd_addr_item),
        .rd_data_valid(fe_rd_data_valid), .rd_data_ready(fe_rd_data_ready),
        .rd_data_item(fe_rd_data_item)
    );

    // Write and read-address paths have equal depth to keep ordering
    stream_stage #(.payload_t(wr_item_t)) wr_stage (
        .clk, .rst_n,
        .in_valid(fe_wr_valid), .in_ready(fe_wr_ready), .in_data(fe_wr_item),
        .out_valid(bk_wr_valid), .out_ready(bk_wr_ready), .out_data(bk_wr_item)
    );

    stream_stage #(.payload_t(rd_addr_item_t)) rd_addr_stage (
        .clk, .rst_n,
        .in_valid(fe_rd_addr_valid), .in_ready(fe_rd_addr_ready), .in_data(fe_rd_addr_item),
        .out_valid(bk_rd_addr_valid), .out_ready(bk_rd_addr_ready),
        .out_data(bk_rd_addr_item)
    );

    stream_stage #(.payload_t(rd_data_item_t)) rd_data_stage (
        .clk, .rst_n,
        .in_valid(bk_rd_data_valid), .in_ready(bk_rd_data_ready), .in_data(bk_rd_data_item),
        .out_valid(fe_rd_data_valid), .out_ready(fe_rd_data_ready),
        .out_data(fe_rd_data_item)
    );

    ext_reg_bank #(.N_CTRL(N_CTRL), .N_STAT(N_STAT)) bank (
        .clk, .rst_n,
        .wr_valid(bk_wr_valid), .wr_ready(bk_wr_ready), .wr_item(bk_wr_item),
        .rd_addr_valid(bk_rd_addr_valid), .rd_addr_ready(bk_rd_addr_ready),
        .rd_addr_item(bk_rd_addr_item),
        .rd_data_valid(bk_rd_data_valid), .rd_data_ready(bk_rd_data_ready),
        .rd_data_item(bk_rd_data_item),
        .status, .ctrl
    );

endmodule

`default_nettype wire

//--- ext_reg_bank.sv
// Control register storage and read lookup over control and status registers
`default_nettype none

module ext_reg_bank
    import reg_stream_pkg::*;
#(
    parameter int N_CTRL = 4,
    parameter int N_STAT = 2
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    wr_valid,
    output logic                    wr_ready,
    input  wr_item_t                wr_item,
    input  logic                    rd_addr_valid,
    output logic                    rd_addr_ready,
    input  rd_addr_item_t           rd_addr_item,
    output logic                    rd_data_valid,
    input  logic                    rd_data_ready,
    output rd_data_item_t           rd_data_item,
    input  logic [N_STAT-1:0][31:0] status,
    output logic [N_CTRL-1:0][31:0] ctrl
);

    logic [N_CTRL-1:0][31:0] ctrl_q;
    logic [31:0]             rd_value;
    logic                    rd_accept;
    logic                    rd_data_valid_q;
    rd_data_item_t           rd_data_q;

    assign wr_ready      = 1'b1;
    // Hold the read-address link while a reply is stalled
    assign rd_addr_ready = !rd_data_valid_q || rd_data_ready;
    assign rd_accept     = rd_addr_valid && rd_addr_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl_q <= '0;
        end else if (wr_valid && wr_ready) begin
            for (int i = 0; i < N_CTRL; i++) begin
                if (wr_item.idx == reg_idx_t'(i)) begin
                    ctrl_q[i] <= wr_item.data;
                end
            end
        end
    end

    // Status words sit right after the control words
    always_comb begin
        rd_value = '0;
        for (int i = 0; i < N_CTRL; i++) begin
            if (rd_addr_item.idx == reg_idx_t'(i)) begin
                rd_value = ctrl_q[i];
            end
        end
        for (int j = 0; j < N_STAT; j++) begin
            if (rd_addr_item.idx == reg_idx_t'(N_CTRL + j)) begin
                rd_value = status[j];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_data_valid_q <= 1'b0;
        end else if (rd_accept) begin
            rd_data_valid_q <= 1'b1;
        end else if (rd_data_ready) begin
            rd_data_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rd_data_q.data <= rd_value;
        end
    end

    assign rd_data_valid = rd_data_valid_q;
    assign rd_data_item  = rd_data_q;
    assign ctrl          = ctrl_q;

endmodule

`default_nettype wire

//--- axil_reg_front.sv
// AXI-lite slave front end: address decode, stream item issue, B and R responses
`default_nettype none

module axil_reg_front
    import axil_pkg::*, reg_stream_pkg::*;
#(
    parameter int N_CTRL = 4,
    parameter int N_STAT = 2
) (
    input  logic          clk,
    input  logic          rst_n,
    input  axil_req_t     axil_req,
    output axil_rsp_t     axil_rsp,
    output logic          wr_valid,
    input  logic          wr_ready,
    output wr_item_t      wr_item,
    output logic          rd_addr_valid,
    input  logic          rd_addr_ready,
    output rd_addr_item_t rd_addr_item,
    input  logic          rd_data_valid,
    output logic          rd_data_ready,
    input  rd_data_item_t rd_data_item
);

    localparam int N_MAP = N_CTRL + N_STAT;

    logic [29:0]   aw_word;
    logic [29:0]   ar_word;
    logic          aw_in_ctrl;
    logic          ar_in_map;
    logic          write_accept;
    logic          read_accept;
    logic          rd_reply;
    logic          b_valid_q;
    logic          r_valid_q;
    logic          wr_valid_q;
    logic          rd_addr_valid_q;
    logic          rd_busy;
    axil_resp_t    b_resp_q;
    axil_resp_t    r_resp_q;
    axil_data_t    r_data_q;
    wr_item_t      wr_item_q;
    rd_addr_item_t rd_addr_item_q;

    // Byte address to word index, full width so high addresses do not alias
    assign aw_word    = axil_req.aw_addr[31:2];
    assign ar_word    = axil_req.ar_addr[31:2];
    assign aw_in_ctrl = aw_word < 30'(N_CTRL);
    assign ar_in_map  = ar_word < 30'(N_MAP);

    // Writes take priority over reads in the same cycle
    assign write_accept = axil_req.aw_valid && axil_req.w_valid && !b_valid_q && !wr_valid_q;
    assign read_accept  = axil_req.ar_valid && !r_valid_q && !rd_busy && !write_accept;
    assign rd_reply     = rd_busy && rd_data_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            b_valid_q       <= 1'b0;
            r_valid_q       <= 1'b0;
            wr_valid_q      <= 1'b0;
            rd_addr_valid_q <= 1'b0;
            rd_busy         <= 1'b0;
        end else begin
            if (write_accept) begin
                b_valid_q <= 1'b1;
            end else if (axil_req.b_ready) begin
                b_valid_q <= 1'b0;
            end

            // Only control addresses produce a write item
            if (write_accept && aw_in_ctrl) begin
                wr_valid_q <= 1'b1;
            end else if (wr_ready) begin
                wr_valid_q <= 1'b0;
            end

            if (read_accept && ar_in_map) begin
                rd_addr_valid_q <= 1'b1;
            end else if (rd_addr_ready) begin
                rd_addr_valid_q <= 1'b0;
            end

            if (read_accept && ar_in_map) begin
                rd_busy <= 1'b1;
            end else if (rd_reply) begin
                rd_busy <= 1'b0;
            end

            // Out-of-map reads answer at once
            if ((read_accept && !ar_in_map) || rd_reply) begin
                r_valid_q <= 1'b1;
            end else if (axil_req.r_ready) begin
                r_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (write_accept) begin
            b_resp_q       <= aw_in_ctrl ? RESP_OKAY : RESP_SLVERR;
            wr_item_q.idx  <= aw_word[REG_IDX_W-1:0];
            wr_item_q.data <= axil_req.w_data;
        end
        if (read_accept) begin
            rd_addr_item_q.idx <= ar_word[REG_IDX_W-1:0];
            r_data_q           <= '0;
            r_resp_q           <= RESP_SLVERR;
        end else if (rd_reply) begin
            r_data_q <= rd_data_item.data;
            r_resp_q <= RESP_OKAY;
        end
    end

    assign wr_valid      = wr_valid_q;
    assign wr_item       = wr_item_q;
    assign rd_addr_valid = rd_addr_valid_q;
    assign rd_addr_item  = rd_addr_item_q;
    assign rd_data_ready = rd_busy;

    always_comb begin
        axil_rsp.aw_ready = write_accept;
        axil_rsp.w_ready  = write_accept;
        axil_rsp.b_valid  = b_valid_q;
        axil_rsp.b_resp   = b_resp_q;
        axil_rsp.ar_ready = read_accept;
        axil_rsp.r_valid  = r_valid_q;
        axil_rsp.r_data   = r_data_q;
        axil_rsp.r_resp   = r_resp_q;
    end

endmodule

`default_nettype wire

//--- stream_stage.sv
// Registered valid/ready pipeline stage with a type-parameterized payload
`default_nettype none

module stream_stage #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     valid_q;
    payload_t data_q;

    // Accept when empty or when the held item leaves this cycle
    assign in_ready = !valid_q || out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (in_valid && in_ready) begin
            valid_q <= 1'b1;
        end else if (out_ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

    assign out_valid = valid_q;
    assign out_data  = data_q;

endmodule

`default_nettype wire

//--- reg_stream_pkg.sv
// Register index type and write, read-address and read-data stream payloads
`default_nettype none

package reg_stream_pkg;

    // Up to 64 word registers
    localparam int REG_IDX_W = 6;

    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    typedef struct packed {
        reg_idx_t    idx;
        logic [31:0] data;
    } wr_item_t;

    typedef struct packed {
        reg_idx_t idx;
    } rd_addr_item_t;

    typedef struct packed {
        logic [31:0] data;
    } rd_data_item_t;

endpackage

`default_nettype wire

//--- axil_pkg.sv
// AXI-lite address, data and response types, request and response channel structs
`default_nettype none

package axil_pkg;

    typedef logic [31:0] axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [1:0]  axil_resp_t;

    localparam axil_resp_t RESP_OKAY   = 2'b00;
    localparam axil_resp_t RESP_SLVERR = 2'b10;

    // Signals driven by the master on all five channels
    typedef struct packed {
        logic       aw_valid;
        axil_addr_t aw_addr;
        logic       w_valid;
        axil_data_t w_data;
        logic       b_ready;
        logic       ar_valid;
        axil_addr_t ar_addr;
        logic       r_ready;
    } axil_req_t;

    // Signals driven by the slave
    typedef struct packed {
        logic       aw_ready;
        logic       w_ready;
        logic       b_valid;
        axil_resp_t b_resp;
        logic       ar_ready;
        logic       r_valid;
        axil_data_t r_data;
        axil_resp_t r_resp;
    } axil_rsp_t;

endpackage

`default_nettype wire
